/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_cache
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP VFLAGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* design/bus_pkg.sv */
// command encodings and request and response structs of the cpu and memory buses
package bus_pkg;

    // cpu side commands, code 3 and 7 unused
    typedef enum logic [2:0] {
        cpu_nop        = 3'd0,
        cpu_read8      = 3'd1,
        cpu_read16     = 3'd2,
        cpu_invalidate = 3'd4,
        cpu_write8     = 3'd5,
        cpu_write16    = 3'd6
    } cpu_cmd_e;

    typedef enum logic [1:0] {
        mem_nop        = 2'd0,
        mem_read_line  = 2'd2,
        mem_write_line = 2'd3
    } mem_cmd_e;

    typedef struct packed {
        cpu_cmd_e         cmd;
        cache_pkg::addr_t addr;
        logic [15:0]      wdata;   // low byte only for write8
    } cpu_req_t;

    typedef struct packed {
        logic        done;
        logic [15:0] rdata;
    } cpu_resp_t;

    typedef struct packed {
        mem_cmd_e                        cmd;
        cache_pkg::line_addr_t           line;
        logic                            wbeat;   // write beat present
        logic [cache_pkg::beat_bits-1:0] wdata;
    } mem_req_t;

    // valid carries read beats, or the single write acknowledge
    typedef struct packed {
        logic                            valid;
        logic [cache_pkg::beat_bits-1:0] rdata;
    } mem_resp_t;

endpackage

/* design/cache_ctrl.sv */
// cache controller: registers cpu requests, merges the two way lookups and runs misses
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                              reset,
    input  logic                              rst,
    input  bus_pkg::cpu_req_t                 cpu_req,
    output bus_pkg::cpu_resp_t                cpu_resp,
    output bus_pkg::mem_req_t                 mem_req,
    input  bus_pkg::mem_resp_t                mem_resp,
    output logic [cache_pkg::set_bits-1:0]    look_set,
    output logic [cache_pkg::tag_bits-1:0]    look_tag,
    input  logic                              hit0,
    input  logic                              hit1,
    input  cache_pkg::line_t                  entry0,
    input  cache_pkg::line_t                  entry1,
    output logic                              store_en0,
    output logic                              store_en1,
    output logic                              fill_en0,
    output logic                              fill_en1,
    output logic                              inval_en0,
    output logic                              inval_en1,
    output logic                              store_half,
    output logic [cache_pkg::offset_bits-1:0] store_offset,
    output logic [15:0]                       store_data,
    output cache_pkg::line_t                  fill_line
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        writeback,
        ack_wait,
        refill,
        respond
    } state_e;

    state_e                                        state;
    bus_pkg::cpu_req_t                             req_q;
    logic [$clog2(cache_pkg::num_ways)-1:0]        way_q;
    logic [$clog2(cache_pkg::num_ways)-1:0]        hit_way;
    logic [$clog2(cache_pkg::num_ways)-1:0]        victim_way;
    logic [$clog2(cache_pkg::num_ways)-1:0]        sel_way;
    logic [$clog2(cache_pkg::num_ways)-1:0]        act_way;
    logic                                          hit_q;
    logic                                          issue_q;
    logic [$clog2(cache_pkg::beats_per_line)-1:0]  beat_cnt;
    logic [cache_pkg::num_sets-1:0]                lru_q;   // most recently used way
    logic [cache_pkg::line_bits-1:0]               beat_buf;
    logic [cache_pkg::line_bits-1:0]               shift_line;
    logic [cache_pkg::beat_bits-1:0]               wb_beat;
    cache_pkg::line_t                              act_entry;
    logic                                          hit_any;
    logic                                          is_write;
    logic                                          is_inval;
    logic                                          is_half;
    logic                                          last_beat;
    logic                                          fill_now;
    logic                                          do_store;
    logic                                          do_inval;

    assign look_set = req_q.addr.set;
    assign look_tag = req_q.addr.tag;

    assign hit_any    = hit0 | hit1;
    assign hit_way    = hit1;
    assign victim_way = ~lru_q[req_q.addr.set];
    assign sel_way    = hit_any ? hit_way : victim_way;
    assign act_way    = (state == lookup) ? sel_way : way_q;
    assign act_entry  = act_way ? entry1 : entry0;

    assign is_write = req_q.cmd inside {bus_pkg::cpu_write8, bus_pkg::cpu_write16};
    assign is_half  = req_q.cmd inside {bus_pkg::cpu_read16, bus_pkg::cpu_write16};
    assign is_inval = (req_q.cmd == bus_pkg::cpu_invalidate);

    assign last_beat  = &beat_cnt;
    assign fill_now   = (state == refill) && mem_resp.valid && last_beat;
    assign shift_line = {mem_resp.rdata, beat_buf[cache_pkg::line_bits-1:cache_pkg::beat_bits]};
    assign wb_beat    = act_entry.data[beat_cnt*cache_pkg::beat_bits +: cache_pkg::beat_bits];

    assign do_store  = (state == respond) && is_write;
    assign do_inval  = (state == respond) && is_inval && hit_q;
    assign store_en0 = do_store && !way_q;
    assign store_en1 = do_store && way_q;
    assign inval_en0 = do_inval && !way_q;
    assign inval_en1 = do_inval && way_q;
    assign fill_en0  = fill_now && !way_q;
    assign fill_en1  = fill_now && way_q;

    assign store_half   = is_half;
    assign store_offset = req_q.addr.offset;
    assign store_data   = req_q.wdata;
    assign fill_line    = '{valid: 1'b1, dirty: 1'b0, tag: req_q.addr.tag, data: shift_line};

    always_comb begin
        cpu_resp.done = (state == respond);
        if (is_half) begin
            cpu_resp.rdata = act_entry.data[req_q.addr.offset*8 +: 16];
        end else begin
            cpu_resp.rdata = {8'h00, act_entry.data[req_q.addr.offset*8 +: 8]};
        end
    end

    always_comb begin
        mem_req.cmd = bus_pkg::mem_nop;
        if (issue_q) begin
            if (state == writeback) begin
                mem_req.cmd = bus_pkg::mem_write_line;
            end else begin
                mem_req.cmd = bus_pkg::mem_read_line;
            end
        end
        mem_req.line.tag = (state == writeback) ? act_entry.tag : req_q.addr.tag;
        mem_req.line.set = req_q.addr.set;
        mem_req.wbeat    = (state == writeback);
        mem_req.wdata    = wb_beat;
    end

    always_ff @(posedge reset) begin
        if (rst) begin
            state    <= idle;
            issue_q  <= 1'b0;
            beat_cnt <= '0;
            lru_q    <= '0;
        end else begin
            issue_q <= 1'b0;
            case (state)
                idle: begin
                    if (cpu_req.cmd != bus_pkg::cpu_nop) begin
                        state <= lookup;
                    end
                end
                lookup: begin
                    if (is_inval) begin
                        if (hit_any && act_entry.dirty) begin
                            state   <= writeback;
                            issue_q <= 1'b1;
                        end else begin
                            state <= respond;
                        end
                    end else if (hit_any) begin
                        state <= respond;
                    end else if (act_entry.valid && act_entry.dirty) begin
                        state   <= writeback;   // evict dirty victim first
                        issue_q <= 1'b1;
                    end else begin
                        state   <= refill;
                        issue_q <= 1'b1;
                    end
                end
                writeback: begin
                    beat_cnt <= beat_cnt + 1'b1;
                    if (last_beat) begin
                        state <= ack_wait;
                    end
                end
                ack_wait: begin
                    if (mem_resp.valid) begin
                        if (is_inval) begin
                            state <= respond;
                        end else begin
                            state   <= refill;
                            issue_q <= 1'b1;
                        end
                    end
                end
                refill: begin
                    if (mem_resp.valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (last_beat) begin
                            lru_q[req_q.addr.set] <= way_q;
                            state                 <= lookup;   // replay as a hit
                        end
                    end
                end
                respond: begin
                    if (!is_inval) begin
                        lru_q[req_q.addr.set] <= way_q;
                    end
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge reset) begin
        if (state == idle) begin
            req_q <= cpu_req;
        end
        if (state == lookup) begin
            way_q <= sel_way;
            hit_q <= hit_any;
        end
        if (state == refill && mem_resp.valid) begin
            beat_buf <= shift_line;   // beat 0 ends up lowest
        end
    end

    a_no_cmd_busy: assert property (
        @(posedge reset) disable iff (rst)
        (state != idle) |-> (cpu_req.cmd == bus_pkg::cpu_nop)
    ) else $error("cpu command while cache busy");

    a_half_aligned: assert property (
        @(posedge reset) disable iff (rst)
        (cpu_req.cmd inside {bus_pkg::cpu_read16, bus_pkg::cpu_write16}) |->
            !cpu_req.addr.offset[0]
    ) else $error("halfword access at odd offset");

    // a line may live in one way only
    a_one_hit: assert property (
        @(posedge reset) disable iff (rst)
        (state != idle) |-> !(hit0 && hit1)
    ) else $error("both ways hit");

endmodule

/* design/cache_pkg.sv */
// cache geometry and line layout, shared by the ways, the controller and the bus types
package cache_pkg;

    localparam int addr_bits      = 19;
    localparam int set_bits       = 5;
    localparam int offset_bits    = 4;
    localparam int tag_bits       = addr_bits - set_bits - offset_bits;

    localparam int num_sets       = 1 << set_bits;
    localparam int num_ways       = 2;

    localparam int line_bytes     = 16;
    localparam int line_bits      = line_bytes * 8;
    localparam int beat_bits      = 16;   // memory bus width
    localparam int beats_per_line = line_bits / beat_bits;

    // byte address as seen on the cpu side
    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [set_bits-1:0]    set;
        logic [offset_bits-1:0] offset;
    } addr_t;

    // one cache entry, state bits on top
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        logic [tag_bits-1:0]  tag;
        logic [line_bits-1:0] data;   // byte k at bits 8k+7:8k
    } line_t;

    // line number on the memory side
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic [set_bits-1:0] set;
    } line_addr_t;

endpackage

/* design/cache_top.sv */
// top of the two-way write-back data cache, joins both ways to the controller
`timescale 1ns/10ps

module cache_top (
    input  logic               reset,
    input  logic               rst,
    input  bus_pkg::cpu_req_t  cpu_req,
    output bus_pkg::cpu_resp_t cpu_resp,
    output bus_pkg::mem_req_t  mem_req,
    input  bus_pkg::mem_resp_t mem_resp
);

    logic [cache_pkg::set_bits-1:0]    look_set;
    logic [cache_pkg::tag_bits-1:0]    look_tag;
    logic                              hit0;
    logic                              hit1;
    cache_pkg::line_t                  entry0;
    cache_pkg::line_t                  entry1;
    logic                              store_en0;
    logic                              store_en1;
    logic                              fill_en0;
    logic                              fill_en1;
    logic                              inval_en0;
    logic                              inval_en1;
    logic                              store_half;
    logic [cache_pkg::offset_bits-1:0] store_offset;
    logic [15:0]                       store_data;
    cache_pkg::line_t                  fill_line;

    cache_ctrl ctrl (
        .reset        (reset),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_resp     (cpu_resp),
        .mem_req      (mem_req),
        .mem_resp     (mem_resp),
        .look_set     (look_set),
        .look_tag     (look_tag),
        .hit0         (hit0),
        .hit1         (hit1),
        .entry0       (entry0),
        .entry1       (entry1),
        .store_en0    (store_en0),
        .store_en1    (store_en1),
        .fill_en0     (fill_en0),
        .fill_en1     (fill_en1),
        .inval_en0    (inval_en0),
        .inval_en1    (inval_en1),
        .store_half   (store_half),
        .store_offset (store_offset),
        .store_data   (store_data),
        .fill_line    (fill_line)
    );

    cache_way way0 (
        .reset        (reset),
        .rst          (rst),
        .look_set     (look_set),
        .look_tag     (look_tag),
        .hit          (hit0),
        .entry        (entry0),
        .store_en     (store_en0),
        .store_half   (store_half),
        .store_offset (store_offset),
        .store_data   (store_data),
        .fill_en      (fill_en0),
        .fill_line    (fill_line),
        .inval_en     (inval_en0)
    );

    cache_way way1 (
        .reset        (reset),
        .rst          (rst),
        .look_set     (look_set),
        .look_tag     (look_tag),
        .hit          (hit1),
        .entry        (entry1),
        .store_en     (store_en1),
        .store_half   (store_half),
        .store_offset (store_offset),
        .store_data   (store_data),
        .fill_en      (fill_en1),
        .fill_line    (fill_line),
        .inval_en     (inval_en1)
    );

endmodule

/* design/cache_way.sv */
// one way of the data cache: line storage, tag compare and line updates, used twice by the top
`timescale 1ns/10ps

module cache_way (
    input  logic                              reset,
    input  logic                              rst,
    input  logic [cache_pkg::set_bits-1:0]    look_set,
    input  logic [cache_pkg::tag_bits-1:0]    look_tag,
    output logic                              hit,
    output cache_pkg::line_t                  entry,
    input  logic                              store_en,
    input  logic                              store_half,
    input  logic [cache_pkg::offset_bits-1:0] store_offset,
    input  logic [15:0]                       store_data,
    input  logic                              fill_en,
    input  cache_pkg::line_t                  fill_line,
    input  logic                              inval_en
);

    logic [cache_pkg::num_sets-1:0]  valid_q;
    logic [cache_pkg::num_sets-1:0]  dirty_q;
    logic [cache_pkg::tag_bits-1:0]  tag_q  [cache_pkg::num_sets];
    logic [cache_pkg::line_bits-1:0] data_q [cache_pkg::num_sets];

    assign entry = '{
        valid: valid_q[look_set],
        dirty: dirty_q[look_set],
        tag:   tag_q[look_set],
        data:  data_q[look_set]
    };

    assign hit = entry.valid && (entry.tag == look_tag);

    // line state
    always_ff @(posedge reset) begin
        if (rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (fill_en) begin
            valid_q[look_set] <= fill_line.valid;
            dirty_q[look_set] <= fill_line.dirty;
        end else if (store_en) begin
            dirty_q[look_set] <= 1'b1;
        end else if (inval_en) begin
            valid_q[look_set] <= 1'b0;
            dirty_q[look_set] <= 1'b0;
        end
    end

    // tags and line data
    always_ff @(posedge reset) begin
        if (fill_en) begin
            tag_q[look_set]  <= fill_line.tag;
            data_q[look_set] <= fill_line.data;
        end else if (store_en) begin
            if (store_half) begin
                data_q[look_set][store_offset*8 +: 16] <= store_data;
            end else begin
                data_q[look_set][store_offset*8 +: 8] <= store_data[7:0];
            end
        end
    end

    // the controller only fills during refill and only stores when responding
    a_store_fill_excl: assert property (
        @(posedge reset) disable iff (rst)
        !(store_en && fill_en)
    ) else $error("store and fill in the same cycle");

endmodule

/* list.f */
design/cache_pkg.sv
design/bus_pkg.sv
design/cache_way.sv
design/cache_ctrl.sv
design/cache_top.sv
tests/mem_model.sv
tests/tb_cache.sv

/* tests/mem_model.sv */
// behavioral memory for the cache testbench, answers line reads and line writes after a random delay
`timescale 1ns/10ps

module mem_model (
    input  logic               reset,
    input  logic               rst,
    input  bus_pkg::mem_req_t  mem_req,
    output bus_pkg::mem_resp_t mem_resp
);

    logic [7:0]            bytes [1 << cache_pkg::addr_bits];
    integer                seed;
    cache_pkg::line_addr_t line_q;

    // a*7+3, folded with the upper address bits
    function automatic logic [7:0] init_byte(input logic [18:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'd7 + 32'd3;
        return v[7:0] ^ a[15:8] ^ {5'd0, a[18:16]};
    endfunction

    task automatic wait_random;
        integer r;
        r = $random(seed);
        repeat (3 + int'(r[2:0])) @(posedge reset);   // 3 to 10 cycles
    endtask

    initial begin
        seed     = 47085;
        mem_resp = '0;
        for (int a = 0; a < (1 << cache_pkg::addr_bits); a++) begin
            bytes[19'(a)] = init_byte(19'(a));
        end
        forever begin
            @(posedge reset);
            if (!rst && mem_req.cmd == bus_pkg::mem_read_line) begin
                line_q = mem_req.line;
                wait_random();
                for (int i = 0; i < 8; i++) begin
                    #1;
                    mem_resp.valid = 1'b1;
                    mem_resp.rdata = {bytes[{line_q, 3'(i), 1'b1}], bytes[{line_q, 3'(i), 1'b0}]};
                    @(posedge reset);
                end
                #1 mem_resp = '0;
            end else if (!rst && mem_req.cmd == bus_pkg::mem_write_line) begin
                line_q = mem_req.line;
                for (int i = 0; i < 8; i++) begin
                    if (i > 0) begin
                        @(posedge reset);
                    end
                    {bytes[{line_q, 3'(i), 1'b1}], bytes[{line_q, 3'(i), 1'b0}]} = mem_req.wdata;
                end
                wait_random();
                #1 mem_resp.valid = 1'b1;   // single acknowledge
                @(posedge reset);
                #1 mem_resp = '0;
            end
        end
    end

endmodule

/* tests/tb_cache.sv */
// testbench top for the data cache: clock, reset, cpu stimulus, reference memory and checks
`timescale 1ns/10ps

module tb_cache;

    localparam int mem_size   = 1 << cache_pkg::addr_bits;
    localparam int max_cycles = 200 * 40;   // 200 ops at 40 cycles worst case

    logic                  reset = 1'b0;
    logic                  rst;
    bus_pkg::cpu_req_t     cpu_req;
    bus_pkg::cpu_resp_t    cpu_resp;
    bus_pkg::mem_req_t     mem_req;
    bus_pkg::mem_resp_t    mem_resp;

    logic [7:0]            ref_mem [mem_size];
    integer                seed;
    int                    errors = 0;
    int                    test_errors;
    int                    cycle = 0;
    logic [15:0]           exp_rdata;
    logic                  pending_read;
    logic                  want_hit;
    logic                  want_miss;
    logic                  want_wb;
    cache_pkg::line_addr_t wb_line_exp;
    logic [7:0]            since_req;
    logic                  seen_read;
    logic                  seen_write;
    logic [2:0]            wb_idx;
    cache_pkg::line_addr_t wb_line_q;
    cache_pkg::line_addr_t wb_line;
    logic [15:0]           wb_exp;

    cache_top uut (
        .reset    (reset),
        .rst      (rst),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    mem_model memory (
        .reset    (reset),
        .rst      (rst),
        .mem_req  (mem_req),
        .mem_resp (mem_resp)
    );

    always #5 reset = ~reset;

    function automatic logic [7:0] ref_byte(input logic [18:0] a);
        logic [31:0] v;
        v = 32'(a) * 32'd7 + 32'd3;
        return v[7:0] ^ a[15:8] ^ {5'd0, a[18:16]};
    endfunction

    function automatic logic [18:0] make_addr(input logic [9:0] tag, input logic [4:0] set,
                                              input logic [3:0] off);
        return {tag, set, off};
    endfunction

    task automatic log_mismatch(input string msg);
        errors++;
        $display("Error at %0t ns: %s", $time, msg);
    endtask

    task automatic report_fault(input string msg);
        errors++;
        $display("at %0t ns the cache misbehaved: %s", $time, msg);
    endtask

    task automatic end_test(input int num, input string name);
        if (errors == test_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    // one cpu command, returns one cycle after done
    task automatic run_op(input bus_pkg::cpu_cmd_e cmd, input logic [18:0] addr,
                          input logic [15:0] wdata, input logic hit, input logic miss);
        want_hit     = hit;
        want_miss    = miss;
        pending_read = (cmd == bus_pkg::cpu_read8) || (cmd == bus_pkg::cpu_read16);
        if (cmd == bus_pkg::cpu_read8) begin
            exp_rdata = {8'h00, ref_mem[addr]};
        end else if (cmd == bus_pkg::cpu_read16) begin
            exp_rdata = {ref_mem[addr | 19'd1], ref_mem[addr]};
        end else if (cmd == bus_pkg::cpu_write8) begin
            ref_mem[addr] = wdata[7:0];
        end else if (cmd == bus_pkg::cpu_write16) begin
            ref_mem[addr]         = wdata[7:0];
            ref_mem[addr | 19'd1] = wdata[15:8];
        end
        cpu_req.cmd   = cmd;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        @(posedge reset);
        #1 cpu_req = '0;
        do @(posedge reset); while (!cpu_resp.done);
        #1;
        pending_read = 1'b0;
        want_hit     = 1'b0;
        want_miss    = 1'b0;
        want_wb      = 1'b0;
    endtask

    // request age, memory commands seen and write-back beat position
    always @(posedge reset) begin
        if (rst) begin
            since_req  <= '0;
            seen_read  <= 1'b0;
            seen_write <= 1'b0;
            wb_idx     <= '0;
        end else begin
            if (cpu_req.cmd != bus_pkg::cpu_nop) begin
                since_req  <= 8'd1;
                seen_read  <= 1'b0;
                seen_write <= 1'b0;
            end else begin
                if (since_req != 8'hff) begin
                    since_req <= since_req + 8'd1;
                end
                if (mem_req.cmd == bus_pkg::mem_read_line) begin
                    seen_read <= 1'b1;
                end
                if (mem_req.cmd == bus_pkg::mem_write_line) begin
                    seen_write <= 1'b1;
                end
            end
            if (mem_req.wbeat) begin
                wb_idx <= wb_idx + 3'd1;
            end
        end
        if (mem_req.cmd == bus_pkg::mem_write_line) begin
            wb_line_q <= mem_req.line;
        end
    end

    assign wb_line = (mem_req.cmd == bus_pkg::mem_write_line) ? mem_req.line : wb_line_q;
    assign wb_exp  = {ref_mem[{wb_line, wb_idx, 1'b1}], ref_mem[{wb_line, wb_idx, 1'b0}]};

    always @(posedge reset) begin
        cycle <= cycle + 1;
        if (cycle == max_cycles) begin
            $display("timeout: the run did not finish within %0d cycles", max_cycles);
            $display("Verification failed");
            $finish;
        end
    end

    a_reset_quiet: assert property (
        @(posedge reset)
        (rst && cycle != 0) |->
            (!cpu_resp.done && mem_req.cmd == bus_pkg::mem_nop && !mem_req.wbeat)
    ) else report_fault("done or a memory command active during reset");

    a_read_value: assert property (
        @(posedge reset) disable iff (rst)
        (cpu_resp.done && pending_read) |-> (cpu_resp.rdata == exp_rdata)
    ) else log_mismatch($sformatf("read data wrong, expected %h", exp_rdata));

    a_hit_latency: assert property (
        @(posedge reset) disable iff (rst)
        (cpu_resp.done && want_hit) |-> (since_req == 8'd2)
    ) else report_fault("hit did not finish 2 cycles after the request");

    a_hit_no_mem: assert property (
        @(posedge reset) disable iff (rst)
        want_hit |-> (mem_req.cmd == bus_pkg::mem_nop)
    ) else report_fault("memory command issued on a hit");

    a_miss_fetch: assert property (
        @(posedge reset) disable iff (rst)
        (cpu_resp.done && want_miss) |-> seen_read
    ) else report_fault("miss finished without a line read");

    a_wb_seen: assert property (
        @(posedge reset) disable iff (rst)
        (cpu_resp.done && want_wb) |-> seen_write
    ) else report_fault("dirty line was not written back");

    a_wb_line: assert property (
        @(posedge reset) disable iff (rst)
        (mem_req.cmd == bus_pkg::mem_write_line && want_wb) |-> (mem_req.line == wb_line_exp)
    ) else log_mismatch($sformatf("write-back line wrong, expected %h", wb_line_exp));

    a_wb_data: assert property (
        @(posedge reset) disable iff (rst)
        mem_req.wbeat |-> (mem_req.wdata == wb_exp)
    ) else log_mismatch($sformatf("write-back beat wrong, expected %h", wb_exp));

    initial begin
        integer            r;
        logic [18:0]       a;
        bus_pkg::cpu_cmd_e cmd;
        seed         = 47085;
        test_errors  = 0;
        rst          = 1'b1;
        cpu_req      = '0;
        pending_read = 1'b0;
        want_hit     = 1'b0;
        want_miss    = 1'b0;
        want_wb      = 1'b0;
        exp_rdata    = '0;
        wb_line_exp  = '0;
        for (int i = 0; i < mem_size; i++) begin
            ref_mem[19'(i)] = ref_byte(19'(i));
        end
        repeat (8) @(posedge reset);
        #1 rst = 1'b0;

        run_op(bus_pkg::cpu_read8, make_addr(10'd1, 5'd2, 4'd5), 16'h0, 1'b0, 1'b1);
        end_test(1, "reset and first read");

        run_op(bus_pkg::cpu_read16, make_addr(10'd1, 5'd2, 4'd6), 16'h0, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_read8, make_addr(10'd1, 5'd2, 4'd15), 16'h0, 1'b1, 1'b0);
        end_test(2, "read hits");

        run_op(bus_pkg::cpu_write8, make_addr(10'd1, 5'd2, 4'd3), 16'h00a5, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_write16, make_addr(10'd1, 5'd2, 4'd8), 16'hbeef, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_read8, make_addr(10'd1, 5'd2, 4'd3), 16'h0, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_read16, make_addr(10'd1, 5'd2, 4'd8), 16'h0, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_write16, make_addr(10'd5, 5'd7, 4'd2), 16'h1234, 1'b0, 1'b1);
        run_op(bus_pkg::cpu_read16, make_addr(10'd5, 5'd7, 4'd2), 16'h0, 1'b1, 1'b0);
        end_test(3, "writes and write allocate");

        run_op(bus_pkg::cpu_read8, make_addr(10'd3, 5'd9, 4'd0), 16'h0, 1'b0, 1'b1);
        run_op(bus_pkg::cpu_write8, make_addr(10'd4, 5'd9, 4'd1), 16'h005a, 1'b0, 1'b1);
        run_op(bus_pkg::cpu_write16, make_addr(10'd4, 5'd9, 4'd4), 16'hc0de, 1'b1, 1'b0);
        run_op(bus_pkg::cpu_read8, make_addr(10'd3, 5'd9, 4'd0), 16'h0, 1'b1, 1'b0);
        want_wb     = 1'b1;
        wb_line_exp = '{tag: 10'd4, set: 5'd9};   // B is the lru victim
        run_op(bus_pkg::cpu_read16, make_addr(10'd6, 5'd9, 4'd2), 16'h0, 1'b0, 1'b1);
        run_op(bus_pkg::cpu_read16, make_addr(10'd3, 5'd9, 4'd0), 16'h0, 1'b1, 1'b0);
        end_test(4, "lru victim write-back");

        run_op(bus_pkg::cpu_write8, make_addr(10'd8, 5'd12, 4'd7), 16'h003c, 1'b0, 1'b1);
        want_wb     = 1'b1;
        wb_line_exp = '{tag: 10'd8, set: 5'd12};
        run_op(bus_pkg::cpu_invalidate, make_addr(10'd8, 5'd12, 4'd0), 16'h0, 1'b0, 1'b0);
        run_op(bus_pkg::cpu_read8, make_addr(10'd8, 5'd12, 4'd7), 16'h0, 1'b0, 1'b1);
        end_test(5, "dirty invalidate");

        for (int n = 0; n < 150; n++) begin
            r = $random(seed);
            a = {8'h2c, r[1:0], 3'b100, r[3:2], r[7:4]};   // sets 16 to 19, four tags
            case (r[9:8])
                2'd0: cmd = bus_pkg::cpu_read8;
                2'd1: cmd = bus_pkg::cpu_read16;
                2'd2: cmd = bus_pkg::cpu_write8;
                default: cmd = bus_pkg::cpu_write16;
            endcase
            if (cmd == bus_pkg::cpu_read16 || cmd == bus_pkg::cpu_write16) begin
                a[0] = 1'b0;
            end
            run_op(cmd, a, r[31:16], 1'b0, 1'b0);
        end
        end_test(6, "random traffic");

        $display("tests run: 6, errors: %0d", errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
